// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = display_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) verif/display_cases.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
source/disp_pkg.sv
source/value_sampler.sv
source/bcd_converter.sv
source/digit_encoder.sv
source/digit_scanner.sv
source/signed_display_top.sv
verif/display_assertions.sv
verif/display_checker.sv
verif/display_tb.sv

// File: source/bcd_converter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_converter #(
	parameter int DATA_WIDTH = 8
) (
	input  wire                               clk,
	input  wire                               rst,
	input  wire signed [DATA_WIDTH-1:0]       sample_i,
	input  wire                               start_i,
	output logic                              busy_o,
	output logic                              done_o,
	output logic                              data_ready_o,
	output logic                              sign_o,
	output logic [disp_pkg::DIGIT_W-1:0]      hundreds_o,
	output logic [disp_pkg::DIGIT_W-1:0]      tens_o,
	output logic [disp_pkg::DIGIT_W-1:0]      ones_o
);

	import disp_pkg::*;

	localparam int   CNT_W   = $clog2(DATA_WIDTH + 1);
	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_WORK = 1'b1;

	logic                  state;
	logic [CNT_W-1:0]      count;	// Passes still to run
	logic                  last_pass;
	logic                  sign_q;
	logic [DATA_WIDTH-1:0] abs_val;
	logic [DATA_WIDTH-1:0] mag_sr;	// Magnitude, consumed from the top
	logic [DIGIT_W-1:0]    h_q, t_q, o_q;
	logic [DIGIT_W-1:0]    h_adj, t_adj, o_adj;
	logic [DIGIT_W-1:0]    h_nx, t_nx, o_nx;

	function automatic logic [DIGIT_W-1:0] add3(input logic [DIGIT_W-1:0] d);
		return (d >= DIGIT_W'(5)) ? d + DIGIT_W'(3) : d;
	endfunction

	// Most negative value still fits as an unsigned magnitude
	assign abs_val = sample_i[DATA_WIDTH-1] ? ~sample_i + DATA_WIDTH'(1) : sample_i;

	assign last_pass = (count == CNT_W'(1));

	// ##################################################
	// One double-dabble pass
	// ##################################################
	assign h_adj = add3(h_q);
	assign t_adj = add3(t_q);
	assign o_adj = add3(o_q);

	assign h_nx = {h_adj[DIGIT_W-2:0], t_adj[DIGIT_W-1]};
	assign t_nx = {t_adj[DIGIT_W-2:0], o_adj[DIGIT_W-1]};
	assign o_nx = {o_adj[DIGIT_W-2:0], mag_sr[DATA_WIDTH-1]};

	// ##################################################
	// Control
	// ##################################################
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state        <= ST_IDLE;
			count        <= '0;
			busy_o       <= 1'b0;
			done_o       <= 1'b0;
			data_ready_o <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start_i)
					begin
						state        <= ST_WORK;
						count        <= CNT_W'(DATA_WIDTH);
						busy_o       <= 1'b1;
						data_ready_o <= 1'b0;
					end
				end
				ST_WORK:
				begin
					count <= count - CNT_W'(1);
					if (last_pass)
					begin
						state        <= ST_IDLE;
						busy_o       <= 1'b0;
						done_o       <= 1'b1;
						data_ready_o <= 1'b1;
					end
				end
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && start_i)
		begin
			sign_q <= sample_i[DATA_WIDTH-1];
			mag_sr <= abs_val;
			h_q    <= '0;
			t_q    <= '0;
			o_q    <= '0;
		end
		else if (state == ST_WORK)
		begin
			mag_sr <= mag_sr << 1;
			h_q    <= h_nx;
			t_q    <= t_nx;
			o_q    <= o_nx;
			if (last_pass)
			begin
				sign_o     <= sign_q;	// Published digits hold until the next done
				hundreds_o <= h_nx;
				tens_o     <= t_nx;
				ones_o     <= o_nx;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/digit_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module digit_encoder (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          done_i,
	input  wire                          sign_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  hundreds_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  tens_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  ones_i,
	output logic [disp_pkg::SEG_W-1:0]   pat_ones_o,
	output logic [disp_pkg::SEG_W-1:0]   pat_tens_o,
	output logic [disp_pkg::SEG_W-1:0]   pat_hund_o,
	output logic [disp_pkg::SEG_W-1:0]   pat_sign_o
);

	import disp_pkg::*;

	logic [SEG_W-1:0] ones_seg;
	logic [SEG_W-1:0] tens_seg;
	logic [SEG_W-1:0] hund_seg;
	logic             hund_zero;
	logic             tens_zero;

	// Non-decimal codes show nothing
	function automatic logic [SEG_W-1:0] digit_seg(input logic [DIGIT_W-1:0] d);
		if (d > DIGIT_W'(9))
			return SEG_BLANK;
		return SEG_DIGIT[d];
	endfunction

	assign ones_seg = digit_seg(ones_i);
	assign tens_seg = digit_seg(tens_i);
	assign hund_seg = digit_seg(hundreds_i);

	assign hund_zero = (hundreds_i == '0);
	assign tens_zero = (tens_i == '0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pat_ones_o <= SEG_BLANK;
			pat_tens_o <= SEG_BLANK;
			pat_hund_o <= SEG_BLANK;
			pat_sign_o <= SEG_BLANK;
		end
		else if (done_i)
		begin
			pat_ones_o <= ones_seg;	// Ones always lit, even for zero
			pat_tens_o <= (hund_zero && tens_zero) ? SEG_BLANK : tens_seg;
			pat_hund_o <= hund_zero ? SEG_BLANK : hund_seg;
			pat_sign_o <= sign_i ? SEG_MINUS : SEG_BLANK;
		end
	end

endmodule

`default_nettype wire

// File: source/digit_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module digit_scanner #(
	parameter int SCAN_DIV = 4
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire [disp_pkg::SEG_W-1:0]    pat_ones_i,
	input  wire [disp_pkg::SEG_W-1:0]    pat_tens_i,
	input  wire [disp_pkg::SEG_W-1:0]    pat_hund_i,
	input  wire [disp_pkg::SEG_W-1:0]    pat_sign_i,
	output logic [disp_pkg::SEG_W-1:0]   seg_o,
	output logic [disp_pkg::NUM_POS-1:0] pos_en_o
);

	import disp_pkg::*;

	localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;

	assign tick = (div_cnt == DIV_W'(SCAN_DIV - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_cnt  <= '0;
			pos_en_o <= '0;	// Nothing lit until the first tick
		end
		else
		begin
			div_cnt <= tick ? '0 : div_cnt + DIV_W'(1);
			if (tick)
				pos_en_o <= (pos_en_o == '0) ? NUM_POS'(1) :
					{pos_en_o[NUM_POS-2:0], pos_en_o[NUM_POS-1]};
		end
	end

	always_comb
	begin
		case (pos_en_o)
			NUM_POS'(1): seg_o = pat_ones_i;
			NUM_POS'(2): seg_o = pat_tens_i;
			NUM_POS'(4): seg_o = pat_hund_i;
			NUM_POS'(8): seg_o = pat_sign_i;
			default:     seg_o = SEG_BLANK;
		endcase
	end

endmodule

`default_nettype wire

// File: source/disp_pkg.sv
`default_nettype none

package disp_pkg;

	// ##################################################
	// Display geometry
	// ##################################################
	localparam int DIGIT_W = 4;	// One BCD digit
	localparam int SEG_W   = 7;	// Segments a to g
	localparam int NUM_POS = 4;	// Ones, tens, hundreds, sign

	// Segment a sits in bit 0, g in bit 6, lit when high
	localparam logic [SEG_W-1:0] SEG_BLANK = 7'h00;
	localparam logic [SEG_W-1:0] SEG_MINUS = 7'h40;	// Only g

	// Indexed by the decimal digit
	localparam logic [9:0][SEG_W-1:0] SEG_DIGIT = {
		7'h6F,	// 9
		7'h7F,	// 8
		7'h07,	// 7
		7'h7D,	// 6
		7'h6D,	// 5
		7'h66,	// 4
		7'h4F,	// 3
		7'h5B,	// 2
		7'h06,	// 1
		7'h3F	// 0
	};

endpackage

`default_nettype wire

// File: source/signed_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module signed_display_top #(
	parameter int DATA_WIDTH = 8,	// 2 to 10 bits
	parameter int SCAN_DIV   = 4
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire signed [DATA_WIDTH-1:0]  value_i,
	output logic                         sign_o,
	output logic [disp_pkg::DIGIT_W-1:0] hundreds_o,
	output logic [disp_pkg::DIGIT_W-1:0] tens_o,
	output logic [disp_pkg::DIGIT_W-1:0] ones_o,
	output logic                         data_ready_o,
	output logic [disp_pkg::SEG_W-1:0]   seg_o,
	output logic [disp_pkg::NUM_POS-1:0] pos_en_o
);

	import disp_pkg::*;

	logic signed [DATA_WIDTH-1:0] sample;
	logic                         start;
	logic                         busy;
	logic                         done;
	logic [SEG_W-1:0]             pat_ones, pat_tens, pat_hund, pat_sign;

	// ##################################################
	// Sampler and converter
	// ##################################################
	value_sampler #(.DATA_WIDTH(DATA_WIDTH)) value_sampler_inst (
		.clk(clk), .rst(rst), .value_i(value_i), .busy_i(busy),
		.sample_o(sample), .start_o(start)
	);

	bcd_converter #(.DATA_WIDTH(DATA_WIDTH)) bcd_converter_inst (
		.clk(clk), .rst(rst), .sample_i(sample), .start_i(start),
		.busy_o(busy), .done_o(done), .data_ready_o(data_ready_o),
		.sign_o(sign_o), .hundreds_o(hundreds_o), .tens_o(tens_o), .ones_o(ones_o)
	);

	// ##################################################
	// Encoder and scanner
	// ##################################################
	digit_encoder digit_encoder_inst (
		.clk(clk), .rst(rst), .done_i(done), .sign_i(sign_o),
		.hundreds_i(hundreds_o), .tens_i(tens_o), .ones_i(ones_o),
		.pat_ones_o(pat_ones), .pat_tens_o(pat_tens),
		.pat_hund_o(pat_hund), .pat_sign_o(pat_sign)
	);

	digit_scanner #(.SCAN_DIV(SCAN_DIV)) digit_scanner_inst (
		.clk(clk), .rst(rst),
		.pat_ones_i(pat_ones), .pat_tens_i(pat_tens),
		.pat_hund_i(pat_hund), .pat_sign_i(pat_sign),
		.seg_o(seg_o), .pos_en_o(pos_en_o)
	);

endmodule

`default_nettype wire

// File: source/value_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module value_sampler #(
	parameter int DATA_WIDTH = 8
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire signed [DATA_WIDTH-1:0]  value_i,
	input  wire                          busy_i,
	output logic signed [DATA_WIDTH-1:0] sample_o,
	output logic                         start_o
);

	logic signed [DATA_WIDTH-1:0] held_q;	// Last value handed to the converter
	logic                         changed;
	logic                         launch;

	assign changed = (value_i != held_q);

	// Converter takes busy high only one cycle after start, so the start cycle
	// itself must not launch again
	assign launch = changed && !busy_i && !start_o;

	assign sample_o = held_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			held_q  <= '0;
			start_o <= 1'b0;
		end
		else
		begin
			start_o <= 1'b0;
			if (launch)
			begin
				held_q  <= value_i;	// Latest value wins while busy
				start_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/display_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module display_assertions (
	input wire                          clk,
	input wire                          rst,
	input wire                          start_i,
	input wire                          busy_i,
	input wire                          data_ready_i,
	input wire [disp_pkg::DIGIT_W-1:0]  hundreds_i,
	input wire [disp_pkg::DIGIT_W-1:0]  tens_i,
	input wire [disp_pkg::DIGIT_W-1:0]  ones_i,
	input wire [disp_pkg::NUM_POS-1:0]  pos_en_i
);

	import disp_pkg::*;

	int fail_count = 0;

	pos_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(pos_en_i))
		else begin $error("pos_en_o not one-hot"); fail_count++; end

	start_idle: assert property (@(posedge clk) disable iff (rst) start_i |-> !busy_i)
		else begin $error("start while converter busy"); fail_count++; end

	// Valid BCD whenever the result is published
	digits_bcd: assert property (@(posedge clk) disable iff (rst)
		data_ready_i |-> (hundreds_i <= 9 && tens_i <= 9 && ones_i <= 9))
		else begin $error("digit above nine"); fail_count++; end

endmodule

bind signed_display_top display_assertions display_assertions_inst (
	.clk(clk), .rst(rst), .start_i(start), .busy_i(busy), .data_ready_i(data_ready_o),
	.hundreds_i(hundreds_o), .tens_i(tens_o), .ones_i(ones_o), .pos_en_i(pos_en_o)
);

`default_nettype wire

// File: verif/display_cases.txt
// One hex word per line: value (12-bit two's complement), sign, hundreds, tens, ones
// Only the low DATA_WIDTH bits of the value are applied
005_0_0_0_5
07F_0_1_2_7
F80_1_1_2_8
FFF_1_0_0_1
064_0_1_0_0
00A_0_0_1_0
000_0_0_0_0
FD3_1_0_4_5
063_0_0_9_9
F9C_1_1_0_0
02A_0_0_4_2
02A_0_0_4_2
FF9_1_0_0_7
FF6_1_0_1_0
009_0_0_0_9

// File: verif/display_checker.sv
`timescale 1ns/1ps
`default_nettype none

module display_checker (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          check_en_i,
	input  wire                          exp_sign_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  exp_hund_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  exp_tens_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  exp_ones_i,
	input  wire                          sign_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  hundreds_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  tens_i,
	input  wire [disp_pkg::DIGIT_W-1:0]  ones_i,
	input  wire                          data_ready_i,
	input  wire [disp_pkg::SEG_W-1:0]    seg_i,
	input  wire [disp_pkg::NUM_POS-1:0]  pos_en_i,
	output int                           error_count_o
);

	import disp_pkg::*;

	logic               rst_q;
	logic [NUM_POS-1:0] prev_pos;
	logic [SEG_W-1:0]   exp_seg;

	initial error_count_o = 0;

	task automatic mismatch(input string name, input int exp_v, input int act_v);
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
		error_count_o++;
	endtask

	// Leading zeros blank and the sign position shows minus
	always_comb
	begin
		case (pos_en_i)
			4'b0001: exp_seg = SEG_DIGIT[exp_ones_i];
			4'b0010: exp_seg = (exp_hund_i == 0 && exp_tens_i == 0) ? SEG_BLANK :
				SEG_DIGIT[exp_tens_i];
			4'b0100: exp_seg = (exp_hund_i == 0) ? SEG_BLANK : SEG_DIGIT[exp_hund_i];
			4'b1000: exp_seg = exp_sign_i ? SEG_MINUS : SEG_BLANK;
			default: exp_seg = SEG_BLANK;
		endcase
	end

	always @(posedge clk)
	begin
		rst_q <= rst;
		if (rst_q)
		begin
			if (data_ready_i !== 1'b0)
				mismatch("data_ready_o", 0, int'(data_ready_i));
			if (pos_en_i !== '0)
				mismatch("pos_en_o", 0, int'(pos_en_i));
		end
		if (check_en_i)
		begin
			if (!data_ready_i)
			begin
				$display("Conversion restarted at %0t although the input did not change", $time);
				error_count_o++;
			end
			if (sign_i !== exp_sign_i)
				mismatch("sign_o", int'(exp_sign_i), int'(sign_i));
			if (hundreds_i !== exp_hund_i)
				mismatch("hundreds_o", int'(exp_hund_i), int'(hundreds_i));
			if (tens_i !== exp_tens_i)
				mismatch("tens_o", int'(exp_tens_i), int'(tens_i));
			if (ones_i !== exp_ones_i)
				mismatch("ones_o", int'(exp_ones_i), int'(ones_i));
			if (pos_en_i != '0 && seg_i !== exp_seg)
				mismatch("seg_o", int'(exp_seg), int'(seg_i));
		end

		// Scan order 0, 1, 2, 3
		if (rst)
			prev_pos <= '0;
		else
		begin
			if (pos_en_i != prev_pos && pos_en_i != {prev_pos[NUM_POS-2:0], prev_pos[NUM_POS-1]}
				&& !(prev_pos == '0 && pos_en_i == NUM_POS'(1)))
			begin
				$display("Position enable jumped from %b to %b at %0t", prev_pos, pos_en_i, $time);
				error_count_o++;
			end
			prev_pos <= pos_en_i;
		end
	end

endmodule

`default_nettype wire

// File: verif/display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module display_tb;

	import disp_pkg::*;

	localparam int DATA_WIDTH = 8;
	localparam int SCAN_DIV   = 4;
	localparam int MAX_CASES  = 64;
	localparam int RAND_COUNT = 40;
	localparam int HOLD       = 3 * NUM_POS * SCAN_DIV;
	localparam int STABLE     = 4;	// High this long means no reconversion pending

	logic                         clk;
	logic                         rst;
	logic signed [DATA_WIDTH-1:0] value;
	logic                         check_en;
	logic                         exp_sign;
	logic [DIGIT_W-1:0]           exp_hund, exp_tens, exp_ones;
	logic                         sign;
	logic [DIGIT_W-1:0]           hundreds, tens, ones;
	logic                         data_ready;
	logic [SEG_W-1:0]             seg;
	logic [NUM_POS-1:0]           pos_en;
	int                           checker_errors;

	// Word layout is value[27:16] then the sign, hundreds, tens and ones nibbles
	logic [27:0] cases [MAX_CASES];
	int          n_cases;
	int          load_errors;
	int          cycle_cnt;
	int          cycle_limit;
	logic [31:0] rng;

	signed_display_top #(.DATA_WIDTH(DATA_WIDTH), .SCAN_DIV(SCAN_DIV)) signed_display_top_inst (
		.clk(clk), .rst(rst), .value_i(value),
		.sign_o(sign), .hundreds_o(hundreds), .tens_o(tens), .ones_o(ones),
		.data_ready_o(data_ready), .seg_o(seg), .pos_en_o(pos_en)
	);

	display_checker checker_inst (
		.clk(clk), .rst(rst), .check_en_i(check_en),
		.exp_sign_i(exp_sign), .exp_hund_i(exp_hund), .exp_tens_i(exp_tens),
		.exp_ones_i(exp_ones),
		.sign_i(sign), .hundreds_i(hundreds), .tens_i(tens), .ones_i(ones),
		.data_ready_i(data_ready), .seg_i(seg), .pos_en_i(pos_en),
		.error_count_o(checker_errors)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ##################################################
	// Stimulus helpers
	// ##################################################
	task automatic expect_value(input logic signed [DATA_WIDTH-1:0] v);
		int m;
		m = int'(v);
		exp_sign = (m < 0);
		if (m < 0)
			m = -m;
		exp_hund = DIGIT_W'(m / 100);
		exp_tens = DIGIT_W'((m / 10) % 10);
		exp_ones = DIGIT_W'(m % 10);
	endtask

	task automatic drive_value(input logic signed [DATA_WIDTH-1:0] v);
		@(posedge clk);
		#1;
		check_en = 1'b0;
		value    = v;
		expect_value(v);
	endtask

	task automatic settle_and_hold();
		int high_cnt;
		high_cnt = 0;
		while (high_cnt < STABLE)
		begin
			@(posedge clk);
			#1;
			high_cnt = data_ready ? high_cnt + 1 : 0;
		end
		check_en = 1'b1;
		repeat (HOLD) @(posedge clk);
	endtask

	// The interrupted conversion publishes first, and the patterns follow a cycle
	// later, just before the pending value clears data_ready again
	task automatic check_first_result();
		@(posedge clk);
		#1;
		while (!data_ready)
		begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		check_en = 1'b1;
		@(posedge clk);
		#1;
		check_en = 1'b0;
	endtask

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, data_ready never settled", cycle_cnt);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial
	begin
		int total;
		clk         = 1'b0;
		rst         = 1'b1;
		value       = '0;
		check_en    = 1'b0;
		exp_sign    = 1'b0;
		exp_hund    = '0;
		exp_tens    = '0;
		exp_ones    = '0;
		load_errors = 0;
		cycle_cnt   = 0;
		cycle_limit = 1000000;
		rng         = 32'd74927;
		for (int i = 0; i < MAX_CASES; i++)
			cases[i] = '1;	// Ones nibble F marks an unused slot
		$readmemh("verif/display_cases.txt", cases);
		n_cases = 0;
		while (n_cases < MAX_CASES && cases[n_cases][3:0] != 4'hF)
			n_cases++;
		if (n_cases == 0)
		begin
			$display("Case file is empty or missing");
			load_errors++;
		end
		cycle_limit = (n_cases + RAND_COUNT + 10) * (DATA_WIDTH + 4 + HOLD) * 2;

		repeat (5) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < n_cases; i++)
		begin
			drive_value(cases[i][16 +: DATA_WIDTH]);
			// File digits override the computed ones
			{exp_sign, exp_hund, exp_tens, exp_ones} = cases[i][12:0];
			settle_and_hold();
		end

		// Input changes while the converter is busy
		drive_value(8'sd77);
		repeat (3) @(posedge clk);
		#1 value = -8'sd99;
		check_first_result();
		expect_value(-8'sd99);
		settle_and_hold();
		drive_value(8'sd5);
		repeat (DATA_WIDTH - 2) @(posedge clk);
		#1 value = -8'sd128;
		check_first_result();
		expect_value(-8'sd128);
		settle_and_hold();

		for (int i = 0; i < RAND_COUNT; i++)
		begin
			rng = xorshift(rng);
			drive_value(rng[DATA_WIDTH-1:0]);
			settle_and_hold();
		end

		total = checker_errors + load_errors
			+ signed_display_top_inst.display_assertions_inst.fail_count;
		$display("Errors: %0d checker, %0d assertion, %0d case file, %0d cases run",
			checker_errors, signed_display_top_inst.display_assertions_inst.fail_count,
			load_errors, n_cases);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
